/* mips_pkg.sv */
package mips_pkg;

        localparam int XLEN = 32;

        typedef logic [XLEN-1:0] word_t;
        typedef logic [4:0]      reg_addr_t;

        localparam word_t RESET_PC = '0;

        // primary opcodes
        localparam logic [5:0] OPC_SPECIAL = 6'h00;
        localparam logic [5:0] OPC_BEQ     = 6'h04;
        localparam logic [5:0] OPC_BNE     = 6'h05;
        localparam logic [5:0] OPC_ADDIU   = 6'h09;
        localparam logic [5:0] OPC_ORI     = 6'h0d;
        localparam logic [5:0] OPC_LUI     = 6'h0f;
        localparam logic [5:0] OPC_LW      = 6'h23;
        localparam logic [5:0] OPC_SW      = 6'h2b;

        // function codes under SPECIAL
        localparam logic [5:0] FN_ADDU = 6'h21;
        localparam logic [5:0] FN_SUBU = 6'h23;
        localparam logic [5:0] FN_AND  = 6'h24;
        localparam logic [5:0] FN_OR   = 6'h25;
        localparam logic [5:0] FN_XOR  = 6'h26;
        localparam logic [5:0] FN_SLT  = 6'h2a;

        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SLT,
                ALU_LUI
        } alu_op_e;

        typedef enum logic [1:0] {
                MEM_NONE,
                MEM_LOAD,
                MEM_STORE
        } mem_op_e;

        typedef struct packed {
                alu_op_e   alu_op;
                mem_op_e   mem_op;
                word_t     op_a;
                word_t     op_b;
                word_t     store_data;
                reg_addr_t dest;
                logic      we;
        } idex_t;

        typedef struct packed {
                word_t     result;
                word_t     store_data;
                mem_op_e   mem_op;
                reg_addr_t dest;
                logic      we;
        } exmm_t;

        typedef struct packed {
                word_t     value;
                reg_addr_t dest;
                logic      we;
        } mmwb_t;

endpackage

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
        input  logic                clk,
        input  logic                rst_n,
        input  mips_pkg::reg_addr_t rs_addr_i,
        input  mips_pkg::reg_addr_t rt_addr_i,
        input  mips_pkg::reg_addr_t wr_addr_i,
        input  logic                wr_en_i,
        input  mips_pkg::word_t     wr_data_i,
        output mips_pkg::word_t     rs_data_o,
        output mips_pkg::word_t     rt_data_o
);
        import mips_pkg::*;

        word_t regs [32];

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_en_i && wr_addr_i != '0) begin
                        regs[wr_addr_i] <= wr_data_i;
                end
        end

        // r0 is never written, so it reads zero
        assign rs_data_o = regs[rs_addr_i];
        assign rt_data_o = regs[rt_addr_i];

endmodule

/* operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
        input  mips_pkg::reg_addr_t rs_addr_i,
        input  mips_pkg::reg_addr_t rt_addr_i,
        input  mips_pkg::word_t     rs_file_i,
        input  mips_pkg::word_t     rt_file_i,
        input  mips_pkg::exmm_t     ex_i,
        input  mips_pkg::reg_addr_t mm_dest_i,
        input  logic                mm_we_i,
        input  mips_pkg::word_t     mm_value_i,
        input  mips_pkg::mmwb_t     wb_i,
        output mips_pkg::word_t     rs_value_o,
        output mips_pkg::word_t     rt_value_o
);
        import mips_pkg::*;

        // youngest writer wins, loads in EX are covered by the interlock
        function automatic word_t pick(input reg_addr_t addr, input word_t file_val);
                word_t v;
                v = file_val;
                if (addr != '0) begin
                        if (ex_i.we && ex_i.mem_op != MEM_LOAD && ex_i.dest == addr) begin
                                v = ex_i.result;
                        end else if (mm_we_i && mm_dest_i == addr) begin
                                v = mm_value_i;
                        end else if (wb_i.we && wb_i.dest == addr) begin
                                v = wb_i.value;
                        end
                end
                return v;
        endfunction

        always_comb begin
                rs_value_o = pick(rs_addr_i, rs_file_i);
                rt_value_o = pick(rt_addr_i, rt_file_i);
        end

endmodule

/* pipeline_ctl.sv */
`timescale 1ns/1ps

module pipeline_ctl (
        input  mips_pkg::reg_addr_t id_rs_i,
        input  mips_pkg::reg_addr_t id_rt_i,
        input  mips_pkg::reg_addr_t ex_dest_i,
        input  logic                ex_is_load_i,
        input  logic                dbus_stall_i,
        output logic                en_fetch_o,
        output logic                en_decode_o,
        output logic                en_mem_o,
        output logic                bubble_o
);
        logic load_use;

        assign load_use = ex_is_load_i && ex_dest_i != '0 &&
                          (ex_dest_i == id_rs_i || ex_dest_i == id_rt_i);

        always_comb begin
                en_fetch_o  = 1'b1;
                en_decode_o = 1'b1;
                en_mem_o    = 1'b1;
                bubble_o    = 1'b0;
                if (dbus_stall_i) begin
                        en_fetch_o  = 1'b0;
                        en_decode_o = 1'b0;
                        en_mem_o    = 1'b0;
                end else if (load_use) begin
                        // hold IF and ID one cycle, send a bubble down to EX
                        en_fetch_o = 1'b0;
                        bubble_o   = 1'b1;
                end
        end

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
        input  logic            clk,
        input  logic            rst_n,
        input  logic            en_i,
        input  logic            branch_taken_i,
        input  mips_pkg::word_t branch_target_i,
        output mips_pkg::word_t ibus_addr_o,
        input  mips_pkg::word_t ibus_rddata_i,
        output mips_pkg::word_t id_pc_o,
        output mips_pkg::word_t id_inst_o
);
        import mips_pkg::*;

        word_t pc_q;
        word_t pc_next;

        // the delay slot is already in IF when decode sees the branch
        assign pc_next = branch_taken_i ? branch_target_i : pc_q + XLEN'(4);

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pc_q      <= RESET_PC;
                        id_pc_o   <= '0;
                        id_inst_o <= '0;
                end else if (en_i) begin
                        pc_q      <= pc_next;
                        id_pc_o   <= pc_q;
                        id_inst_o <= ibus_rddata_i;
                end
        end

        assign ibus_addr_o = pc_q;

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
        input  logic                clk,
        input  logic                rst_n,
        input  logic                en_i,
        input  logic                bubble_i,
        input  mips_pkg::word_t     pc_i,
        input  mips_pkg::word_t     inst_i,
        output mips_pkg::reg_addr_t rs_addr_o,
        output mips_pkg::reg_addr_t rt_addr_o,
        input  mips_pkg::word_t     rs_value_i,
        input  mips_pkg::word_t     rt_value_i,
        output logic                branch_taken_o,
        output mips_pkg::word_t     branch_target_o,
        output mips_pkg::idex_t     idex_o
);
        import mips_pkg::*;

        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [15:0] imm;
        word_t       imm_sext;
        word_t       imm_zext;
        idex_t       idex_d;

        assign opcode    = inst_i[31:26];
        assign rs_addr_o = inst_i[25:21];
        assign rt_addr_o = inst_i[20:16];
        assign funct     = inst_i[5:0];
        assign imm       = inst_i[15:0];
        assign imm_sext  = {{16{imm[15]}}, imm};
        assign imm_zext  = {16'h0000, imm};

        // target is relative to the delay slot
        assign branch_target_o = pc_i + XLEN'(4) + {imm_sext[29:0], 2'b00};

        always_comb begin
                idex_d            = '0;
                idex_d.alu_op     = ALU_ADD;
                idex_d.mem_op     = MEM_NONE;
                idex_d.op_a       = rs_value_i;
                idex_d.op_b       = rt_value_i;
                idex_d.store_data = rt_value_i;
                idex_d.dest       = inst_i[15:11];
                idex_d.we         = 1'b0;
                branch_taken_o    = 1'b0;
                case (opcode)
                OPC_SPECIAL: begin
                        idex_d.we = 1'b1;
                        case (funct)
                        FN_ADDU: idex_d.alu_op = ALU_ADD;
                        FN_SUBU: idex_d.alu_op = ALU_SUB;
                        FN_AND:  idex_d.alu_op = ALU_AND;
                        FN_OR:   idex_d.alu_op = ALU_OR;
                        FN_XOR:  idex_d.alu_op = ALU_XOR;
                        FN_SLT:  idex_d.alu_op = ALU_SLT;
                        default: idex_d.we = 1'b0;
                        endcase
                end
                OPC_ADDIU, OPC_ORI, OPC_LUI, OPC_LW: begin
                        idex_d.dest = rt_addr_o;
                        idex_d.we   = 1'b1;
                        idex_d.op_b = (opcode == OPC_ADDIU || opcode == OPC_LW) ?
                                      imm_sext : imm_zext;
                        if (opcode == OPC_ORI) begin
                                idex_d.alu_op = ALU_OR;
                        end else if (opcode == OPC_LUI) begin
                                idex_d.alu_op = ALU_LUI;
                        end else if (opcode == OPC_LW) begin
                                idex_d.mem_op = MEM_LOAD;
                        end
                end
                OPC_SW: begin
                        idex_d.op_b   = imm_sext;
                        idex_d.mem_op = MEM_STORE;
                end
                OPC_BEQ: branch_taken_o = (rs_value_i == rt_value_i);
                OPC_BNE: branch_taken_o = (rs_value_i != rt_value_i);
                default: ;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        idex_o.mem_op <= MEM_NONE;
                        idex_o.we     <= 1'b0;
                end else if (en_i) begin
                        if (bubble_i) begin
                                idex_o.mem_op <= MEM_NONE;
                                idex_o.we     <= 1'b0;
                        end else begin
                                idex_o <= idex_d;
                        end
                end
        end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
        input  logic            clk,
        input  logic            rst_n,
        input  logic            en_i,
        input  mips_pkg::idex_t idex_i,
        output mips_pkg::exmm_t ex_next_o,
        output mips_pkg::exmm_t exmm_o
);
        import mips_pkg::*;

        word_t alu_res;

        // loads and stores use ALU_ADD for the address
        always_comb begin
                case (idex_i.alu_op)
                ALU_ADD: alu_res = idex_i.op_a + idex_i.op_b;
                ALU_SUB: alu_res = idex_i.op_a - idex_i.op_b;
                ALU_AND: alu_res = idex_i.op_a & idex_i.op_b;
                ALU_OR:  alu_res = idex_i.op_a | idex_i.op_b;
                ALU_XOR: alu_res = idex_i.op_a ^ idex_i.op_b;
                ALU_SLT: alu_res = XLEN'($signed(idex_i.op_a) < $signed(idex_i.op_b));
                ALU_LUI: alu_res = {idex_i.op_b[15:0], 16'h0000};
                default: alu_res = '0;
                endcase
        end

        always_comb begin
                ex_next_o.result     = alu_res;
                ex_next_o.store_data = idex_i.store_data;
                ex_next_o.mem_op     = idex_i.mem_op;
                ex_next_o.dest       = idex_i.dest;
                ex_next_o.we         = idex_i.we;
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        exmm_o.mem_op <= MEM_NONE;
                        exmm_o.we     <= 1'b0;
                end else if (en_i) begin
                        exmm_o <= ex_next_o;
                end
        end

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
        input  logic            clk,
        input  logic            rst_n,
        input  logic            en_i,
        input  mips_pkg::exmm_t exmm_i,
        output mips_pkg::word_t dbus_addr_o,
        output mips_pkg::word_t dbus_wdata_o,
        output logic            dbus_rd_o,
        output logic            dbus_wr_o,
        input  mips_pkg::word_t dbus_rddata_i,
        output mips_pkg::word_t mm_value_o,
        output mips_pkg::mmwb_t mmwb_o
);
        import mips_pkg::*;

        assign dbus_addr_o  = exmm_i.result;
        assign dbus_wdata_o = exmm_i.store_data;
        assign dbus_rd_o    = (exmm_i.mem_op == MEM_LOAD);
        assign dbus_wr_o    = (exmm_i.mem_op == MEM_STORE);

        // load data is only meaningful once the bus stops stalling
        assign mm_value_o = dbus_rd_o ? dbus_rddata_i : exmm_i.result;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        mmwb_o.we <= 1'b0;
                end else if (!en_i) begin
                        // access still pending, nothing retires this cycle
                        mmwb_o.we <= 1'b0;
                end else begin
                        mmwb_o.value <= mm_value_o;
                        mmwb_o.dest  <= exmm_i.dest;
                        mmwb_o.we    <= exmm_i.we;
                end
        end

endmodule

/* mips_core.sv */
`timescale 1ns/1ps

module mips_core (
        input  logic            clk,
        input  logic            rst_n,
        output mips_pkg::word_t ibus_addr_o,
        input  mips_pkg::word_t ibus_rddata_i,
        output mips_pkg::word_t dbus_addr_o,
        output mips_pkg::word_t dbus_wdata_o,
        output logic            dbus_rd_o,
        output logic            dbus_wr_o,
        input  mips_pkg::word_t dbus_rddata_i,
        input  logic            dbus_stall_i
);
        import mips_pkg::*;

        logic      en_fetch;
        logic      en_decode;
        logic      en_mem;
        logic      bubble;
        word_t     if_pc;
        word_t     if_inst;
        logic      branch_taken;
        word_t     branch_target;
        reg_addr_t id_rs;
        reg_addr_t id_rt;
        word_t     rs_file;
        word_t     rt_file;
        word_t     rs_value;
        word_t     rt_value;
        idex_t     idex;
        exmm_t     ex_next;
        exmm_t     exmm;
        word_t     mm_value;
        mmwb_t     mmwb;

        pipeline_ctl u_ctl (
                .id_rs_i      (id_rs),
                .id_rt_i      (id_rt),
                .ex_dest_i    (idex.dest),
                .ex_is_load_i (idex.mem_op == MEM_LOAD),
                .dbus_stall_i (dbus_stall_i),
                .en_fetch_o   (en_fetch),
                .en_decode_o  (en_decode),
                .en_mem_o     (en_mem),
                .bubble_o     (bubble)
        );

        fetch_stage u_fetch (
                .clk             (clk),
                .rst_n           (rst_n),
                .en_i            (en_fetch),
                .branch_taken_i  (branch_taken),
                .branch_target_i (branch_target),
                .ibus_addr_o     (ibus_addr_o),
                .ibus_rddata_i   (ibus_rddata_i),
                .id_pc_o         (if_pc),
                .id_inst_o       (if_inst)
        );

        decode_stage u_decode (
                .clk             (clk),
                .rst_n           (rst_n),
                .en_i            (en_decode),
                .bubble_i        (bubble),
                .pc_i            (if_pc),
                .inst_i          (if_inst),
                .rs_addr_o       (id_rs),
                .rt_addr_o       (id_rt),
                .rs_value_i      (rs_value),
                .rt_value_i      (rt_value),
                .branch_taken_o  (branch_taken),
                .branch_target_o (branch_target),
                .idex_o          (idex)
        );

        reg_file u_regs (
                .clk       (clk),
                .rst_n     (rst_n),
                .rs_addr_i (id_rs),
                .rt_addr_i (id_rt),
                .wr_addr_i (mmwb.dest),
                .wr_en_i   (mmwb.we),
                .wr_data_i (mmwb.value),
                .rs_data_o (rs_file),
                .rt_data_o (rt_file)
        );

        operand_forward u_fwd (
                .rs_addr_i  (id_rs),
                .rt_addr_i  (id_rt),
                .rs_file_i  (rs_file),
                .rt_file_i  (rt_file),
                .ex_i       (ex_next),
                .mm_dest_i  (exmm.dest),
                .mm_we_i    (exmm.we),
                .mm_value_i (mm_value),
                .wb_i       (mmwb),
                .rs_value_o (rs_value),
                .rt_value_o (rt_value)
        );

        execute_stage u_execute (
                .clk       (clk),
                .rst_n     (rst_n),
                .en_i      (en_mem),
                .idex_i    (idex),
                .ex_next_o (ex_next),
                .exmm_o    (exmm)
        );

        memory_stage u_memory (
                .clk           (clk),
                .rst_n         (rst_n),
                .en_i          (en_mem),
                .exmm_i        (exmm),
                .dbus_addr_o   (dbus_addr_o),
                .dbus_wdata_o  (dbus_wdata_o),
                .dbus_rd_o     (dbus_rd_o),
                .dbus_wr_o     (dbus_wr_o),
                .dbus_rddata_i (dbus_rddata_i),
                .mm_value_o    (mm_value),
                .mmwb_o        (mmwb)
        );

endmodule

/* tb_isa_model.svh */
function automatic word_t enc_r(input logic [5:0] fn, input reg_addr_t rd,
                                input reg_addr_t rs, input reg_addr_t rt);
        return {mips_pkg::OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rt,
                                input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
endfunction

// offset field of a branch at word "from" that lands on word "to"
function automatic logic [15:0] br_off(input int from, input int to);
        return 16'(to - (from + 1));
endfunction

// fills imem of the including module, END_WORD holds the closing self-loop
function automatic void build_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
                imem[i] = '0;
        end
        // dependent ALU chain
        imem[0]  = enc_i(OPC_ADDIU, 1, 0, 16'($urandom));
        imem[1]  = enc_i(OPC_ADDIU, 2, 1, 16'($urandom));
        imem[2]  = enc_r(FN_ADDU, 3, 1, 2);
        imem[3]  = enc_r(FN_SUBU, 4, 3, 1);
        imem[4]  = enc_r(FN_XOR, 5, 4, 2);
        imem[5]  = enc_r(FN_SLT, 6, 5, 3);
        imem[6]  = enc_i(OPC_ORI, 7, 5, 16'($urandom));
        imem[7]  = enc_i(OPC_LUI, 8, 0, 16'($urandom));
        imem[8]  = enc_r(FN_OR, 9, 8, 7);
        imem[9]  = enc_i(OPC_SW, 3, 0, 16'd0);
        imem[10] = enc_i(OPC_SW, 4, 0, 16'd4);
        imem[11] = enc_i(OPC_SW, 5, 0, 16'd8);
        imem[12] = enc_i(OPC_SW, 6, 0, 16'd12);
        imem[13] = enc_i(OPC_SW, 9, 0, 16'd16);
        // load-use, reload of stored data, branch on a loaded value
        imem[14] = enc_i(OPC_LW, 10, 0, 16'd16);
        imem[15] = enc_r(FN_ADDU, 11, 10, 1);
        imem[16] = enc_i(OPC_SW, 11, 0, 16'd20);
        imem[17] = enc_i(OPC_LW, 12, 0, 16'd40);
        imem[18] = enc_i(OPC_BNE, 0, 12, br_off(18, 21));
        imem[19] = enc_i(OPC_ADDIU, 13, 0, 16'($urandom));
        imem[20] = enc_i(OPC_ADDIU, 13, 13, 16'd1);
        imem[21] = enc_i(OPC_SW, 13, 0, 16'd24);
        // taken and not-taken branches
        imem[22] = enc_i(OPC_BEQ, 1, 1, br_off(22, 25));
        imem[23] = enc_i(OPC_ADDIU, 14, 0, 16'd7);
        imem[24] = enc_i(OPC_ADDIU, 14, 14, 16'd100);
        imem[25] = enc_i(OPC_BNE, 0, 0, br_off(25, 27));
        imem[26] = enc_i(OPC_ADDIU, 14, 14, 16'd3);
        imem[27] = enc_i(OPC_SW, 14, 0, 16'd28);
        // counted loop with the store in the delay slot
        imem[28] = enc_i(OPC_ADDIU, 15, 0, 16'd5);
        imem[29] = enc_i(OPC_ADDIU, 16, 0, 16'd0);
        imem[30] = enc_r(FN_ADDU, 16, 16, 15);
        imem[31] = enc_i(OPC_ADDIU, 15, 15, 16'hffff);
        imem[32] = enc_i(OPC_BNE, 0, 15, br_off(32, 30));
        imem[33] = enc_i(OPC_SW, 16, 0, 16'd32);
        // r0 stays zero
        imem[34] = enc_i(OPC_ADDIU, 0, 0, 16'($urandom) | 16'h1);
        imem[35] = enc_i(OPC_SW, 0, 0, 16'd36);
        imem[END_WORD] = enc_i(OPC_BEQ, 0, 0, br_off(END_WORD, END_WORD));
endfunction

// runs the program in order and returns {address, data} of every store
function automatic pair_q_t ref_run();
        pair_q_t     q;
        word_t       r [32];
        word_t       m [DMEM_WORDS];
        word_t       inst;
        word_t       pc;
        word_t       npc;
        word_t       sx;
        word_t       zx;
        word_t       addr;
        logic [5:0]  op;
        logic        taken;
        for (int i = 0; i < 32; i++) begin
                r[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
                m[i] = dmem_init[i];
        end
        pc  = RESET_PC;
        npc = RESET_PC + 4;
        for (int step = 0; step < 1000 && pc != word_t'(END_WORD * 4); step++) begin
                inst  = imem[pc[7:2]];
                op    = inst[31:26];
                sx    = {{16{inst[15]}}, inst[15:0]};
                zx    = {16'h0000, inst[15:0]};
                addr  = r[inst[25:21]] + sx;
                taken = 1'b0;
                if (op == OPC_SPECIAL) begin
                        case (inst[5:0])
                        FN_ADDU: r[inst[15:11]] = r[inst[25:21]] + r[inst[20:16]];
                        FN_SUBU: r[inst[15:11]] = r[inst[25:21]] - r[inst[20:16]];
                        FN_AND:  r[inst[15:11]] = r[inst[25:21]] & r[inst[20:16]];
                        FN_OR:   r[inst[15:11]] = r[inst[25:21]] | r[inst[20:16]];
                        FN_XOR:  r[inst[15:11]] = r[inst[25:21]] ^ r[inst[20:16]];
                        FN_SLT:  r[inst[15:11]] = word_t'($signed(r[inst[25:21]]) <
                                                          $signed(r[inst[20:16]]));
                        default: ;
                        endcase
                end else if (op == OPC_ADDIU) begin
                        r[inst[20:16]] = r[inst[25:21]] + sx;
                end else if (op == OPC_ORI) begin
                        r[inst[20:16]] = r[inst[25:21]] | zx;
                end else if (op == OPC_LUI) begin
                        r[inst[20:16]] = {inst[15:0], 16'h0000};
                end else if (op == OPC_LW) begin
                        r[inst[20:16]] = m[addr[9:2]];
                end else if (op == OPC_SW) begin
                        m[addr[9:2]] = r[inst[20:16]];
                        q.push_back({addr, r[inst[20:16]]});
                end else if (op == OPC_BEQ) begin
                        taken = (r[inst[25:21]] == r[inst[20:16]]);
                end else if (op == OPC_BNE) begin
                        taken = (r[inst[25:21]] != r[inst[20:16]]);
                end
                r[0] = '0;
                pc   = npc;
                npc  = taken ? pc + {sx[29:0], 2'b00} : npc + 4;
        end
        return q;
endfunction

/* tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core;
        import mips_pkg::*;

        typedef logic [63:0] pair_q_t [$];

        localparam int IMEM_WORDS  = 64;
        localparam int DMEM_WORDS  = 256;
        localparam int END_WORD    = 36;
        // roughly 50 instructions execute
        // stalls and interlocks average well below 8 cycles each
        localparam int INST_BUDGET = 64;
        localparam int WORST_CPI   = 8;
        localparam int MAX_CYCLES  = INST_BUDGET * WORST_CPI + 100;

        logic  clk;
        logic  rst_n;
        word_t ibus_addr;
        word_t ibus_rddata;
        word_t dbus_addr;
        word_t dbus_wdata;
        logic  dbus_rd;
        logic  dbus_wr;
        word_t dbus_rddata;
        logic  dbus_stall;

        word_t   imem      [IMEM_WORDS];
        word_t   dmem      [DMEM_WORDS];
        word_t   dmem_init [DMEM_WORDS];
        pair_q_t exp_q;
        int      store_count;
        int      value_errors;
        int      other_errors;
        int      cycles;
        logic    pend_wr;
        word_t   held_addr;
        word_t   held_data;

        `include "tb_isa_model.svh"

        mips_core UUT (
                .clk           (clk),
                .rst_n         (rst_n),
                .ibus_addr_o   (ibus_addr),
                .ibus_rddata_i (ibus_rddata),
                .dbus_addr_o   (dbus_addr),
                .dbus_wdata_o  (dbus_wdata),
                .dbus_rd_o     (dbus_rd),
                .dbus_wr_o     (dbus_wr),
                .dbus_rddata_i (dbus_rddata),
                .dbus_stall_i  (dbus_stall)
        );

        assign ibus_rddata = imem[ibus_addr[7:2]];
        assign dbus_rddata = dmem[dbus_addr[9:2]];

        task automatic check_value(input string name, input word_t got, input word_t exp);
                if (got !== exp) begin
                        $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
                        value_errors++;
                end
        endtask

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        // data memory, store stream comparison and bus stability while stalled
        always @(posedge clk) begin
                if (!rst_n) begin
                        if (dbus_rd === 1'b1 || dbus_wr === 1'b1) begin
                                $display("data bus strobe high during reset at %0t", $time);
                                other_errors++;
                        end
                        pend_wr <= 1'b0;
                end else begin
                        if (pend_wr) begin
                                if (dbus_wr !== 1'b1) begin
                                        $display("store dropped while stalled at %0t", $time);
                                        other_errors++;
                                end
                                check_value("dbus_addr_o", dbus_addr, held_addr);
                                check_value("dbus_wdata_o", dbus_wdata, held_data);
                        end
                        pend_wr   <= dbus_wr && dbus_stall;
                        held_addr <= dbus_addr;
                        held_data <= dbus_wdata;
                        if (dbus_wr && !dbus_stall) begin
                                dmem[dbus_addr[9:2]] <= dbus_wdata;
                                if (store_count < exp_q.size()) begin
                                        check_value("dbus_addr_o", dbus_addr,
                                                    exp_q[store_count][63:32]);
                                        check_value("dbus_wdata_o", dbus_wdata,
                                                    exp_q[store_count][31:0]);
                                end else begin
                                        $display("unexpected extra store at %0t", $time);
                                        other_errors++;
                                end
                                store_count++;
                        end
                end
        end

        // stall on roughly a third of the cycles
        always @(posedge clk) begin
                #1;
                dbus_stall = rst_n && ($urandom % 3 == 0);
        end

        initial begin
                rst_n        = 1'b0;
                dbus_stall   = 1'b0;
                store_count  = 0;
                value_errors = 0;
                other_errors = 0;
                cycles       = 0;
                void'($urandom(32'h4d91_aefc));
                for (int i = 0; i < DMEM_WORDS; i++) begin
                        dmem_init[i] = $urandom;
                        dmem[i]      = dmem_init[i];
                end
                build_program();
                exp_q = ref_run();
                repeat (10) @(posedge clk);
                #1;
                rst_n = 1'b1;
                // PC still holds its reset value until the next rising edge
                @(negedge clk);
                check_value("ibus_addr_o", ibus_addr, RESET_PC);
                while (store_count < exp_q.size() && cycles < MAX_CYCLES) begin
                        @(negedge clk);
                        cycles++;
                end
                if (cycles >= MAX_CYCLES) begin
                        $display("timeout after %0d cycles, %0d of %0d stores seen",
                                 cycles, store_count, exp_q.size());
                        other_errors++;
                end else begin
                        // let the end loop spin to catch stray stores
                        repeat (20) @(posedge clk);
                end
                $display("errors: %0d value mismatches, %0d other failures",
                         value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0) begin
                        $display("RESULT: PASS");
                end else begin
                        $display("RESULT: FAIL");
                end
                $finish;
        end

endmodule

/* build.f */
+incdir+.
mips_pkg.sv
reg_file.sv
operand_forward.sv
pipeline_ctl.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
tb_mips_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
